//--- test/eclock_vectors.txt
// columns: config word, cclk period, lclk period, lclk_div4 period, window cycles
// all hex, a period of 0 means that output is held low
0113 0002 0002 0008 0020
0223 0004 0004 0010 0040
0333 0008 0008 0020 0080
0443 0010 0010 0040 00c0
0553 0020 0020 0080 0180
0673 0080 0040 0080 0180
0763 0040 0080 0080 0180
0f93 0080 0080 0080 0180
0331 0008 0000 0020 0060
0332 0000 0008 0020 0060
0333 0008 0008 0020 0060
0203 0000 0004 0010 0030
0023 0004 0000 0004 0030
0210 0000 0000 0010 0030
0113 0002 0002 0008 0020

//--- all.f
hw/eclock_pkg.sv
hw/eclock_cfg.sv
hw/clock_divider.sv
hw/eclock_gate.sv
hw/eclocks.sv
test/eclocks_tb.sv

//--- Makefile
# Verilator build for the elink clock generator

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= eclocks_tb
RTL_TOP   ?= eclocks
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

# lint the design top on its own
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

# run from the project root so the vector file path resolves
sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/eclocks_tb.sv
// elink clock generator testbench
`timescale 1ns/10ps

module eclocks_tb;

   localparam int NUM_VEC     = 15;    // rows in the vector file
   localparam int VEC_COLS    = 5;     // word, three periods, window
   localparam int RAND_RUNS   = 4;
   localparam int RAND_WINDOW = 400;   // covers three periods of 128
   localparam int SKIP_SLACK  = 300;   // write plus settle time per test

   logic                  pll_clk;
   logic                  rst;
   logic                  cfg_write;
   eclock_pkg::cfg_word_t cfg_data;
   logic                  cclk_p;
   logic                  cclk_n;
   logic                  tx_lclk;
   logic                  tx_lclk90;
   logic                  tx_lclk_div4;

   logic [15:0] vec_mem [0:NUM_VEC*VEC_COLS-1];
   int          budget_cycles = 0;     // watchdog arms once nonzero
   int          seed = 30869;

   // per channel edge tracking in order cclk_p tx_lclk tx_lclk90 tx_lclk_div4
   logic  prev_lvl   [0:3];
   logic  seen_rise  [0:3];
   int    last_rise  [0:3];
   int    rise_count [0:3];
   string chan_name  [0:3] = '{"cclk_p", "tx_lclk", "tx_lclk90", "tx_lclk_div4"};

   eclocks UUT (
      .pll_clk      (pll_clk),
      .rst          (rst),
      .cfg_write    (cfg_write),
      .cfg_data     (cfg_data),
      .cclk_p       (cclk_p),
      .cclk_n       (cclk_n),
      .tx_lclk      (tx_lclk),
      .tx_lclk90    (tx_lclk90),
      .tx_lclk_div4 (tx_lclk_div4)
   );

   initial pll_clk = 1'b0;
   always #50 pll_clk = ~pll_clk;      // 100 ns period

   // ##############################
   // helpers
   // ##############################
   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("mismatch %s expected %0d actual %0d", name, expected, actual);
         $display("sim failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   // period 2^n with n clamped at 7 and 0 for held low
   function automatic int rule_period(input int setting);
      int n;
      n = (setting > eclock_pkg::DIV_MAX) ? eclock_pkg::DIV_MAX : setting;
      if (n == 0) begin
         return 0;
      end
      return 1 << n;
   endfunction

   task automatic expected_periods(input eclock_pkg::cfg_word_t word,
                                   output int pc, output int pl, output int pd);
      int cs;
      int ls;
      cs = int'(word[7:4]);            // cclk setting
      ls = int'(word[11:8]);           // lclk setting
      if (ls > eclock_pkg::DIV_MAX) begin
         ls = eclock_pkg::DIV_MAX;
      end
      pc = word[0] ? rule_period(cs) : 0;
      pl = word[1] ? rule_period(ls) : 0;
      pd = rule_period(ls + eclock_pkg::DIV4_OFFSET);   // ignores lclk enable
   endtask

   task automatic check_idle(input string tag);
      check_value({tag, " cclk_p"}, 0, int'(cclk_p));
      check_value({tag, " cclk_n"}, 1, int'(cclk_n));
      check_value({tag, " tx_lclk"}, 0, int'(tx_lclk));
      check_value({tag, " tx_lclk90"}, 0, int'(tx_lclk90));
      check_value({tag, " tx_lclk_div4"}, 0, int'(tx_lclk_div4));
   endtask

   // checks spacing and high time of full pulses on one channel
   task automatic track_channel(input int ch, input string name, input logic lvl,
                                input int period, input int t);
      if (period == 0) begin
         check_value({name, " held low"}, 0, int'(lvl));
      end else if (!prev_lvl[ch] && lvl) begin
         if (seen_rise[ch]) begin
            check_value({name, " period"}, period, t - last_rise[ch]);
         end
         seen_rise[ch]  = 1'b1;
         last_rise[ch]  = t;
         rise_count[ch] = rise_count[ch] + 1;
      end else if (prev_lvl[ch] && !lvl && seen_rise[ch]) begin
         check_value({name, " high time"}, period / 2, t - last_rise[ch]);
      end
      prev_lvl[ch] = lvl;
   endtask

   task automatic measure_window(input string tag, input int pc, input int pl,
                                 input int pd, input int window);
      int         periods [0:3];
      logic [3:0] lvls;
      int         t;
      int         ch;
      periods[0] = pc;
      periods[1] = pl;
      periods[2] = pl;                 // 90 copy shares the lclk period
      periods[3] = pd;
      for (ch = 0; ch < 4; ch++) begin
         seen_rise[ch]  = 1'b0;
         rise_count[ch] = 0;
      end
      for (t = 0; t < window; t++) begin
         @(negedge pll_clk);           // outputs settled since the rising edge
         lvls = {tx_lclk_div4, tx_lclk90, tx_lclk, cclk_p};
         check_value({tag, " cclk_n inverse"}, 1, int'(cclk_n == !cclk_p));
         if (pl == 2) begin
            check_value({tag, " tx_lclk90 equals tx_lclk"}, int'(tx_lclk), int'(tx_lclk90));
         end
         if (t == 0) begin
            for (ch = 0; ch < 4; ch++) begin
               prev_lvl[ch] = lvls[ch];   // pulses already running are skipped
            end
         end else begin
            // quarter period lag of tx_lclk90 behind the last lclk rise
            if (pl > 2 && !prev_lvl[2] && lvls[2] && seen_rise[1]) begin
               check_value({tag, " tx_lclk90 lag"}, pl / 4, t - last_rise[1]);
            end
            for (ch = 0; ch < 4; ch++) begin
               track_channel(ch, {tag, " ", chan_name[ch]}, lvls[ch], periods[ch], t);
            end
         end
      end
      for (ch = 0; ch < 4; ch++) begin
         if (periods[ch] != 0) begin
            check_value({tag, " ", chan_name[ch], " two rises seen"}, 1,
                        int'(rise_count[ch] >= 2));
         end
      end
   endtask

   task automatic write_config(input eclock_pkg::cfg_word_t word);
      cfg_write = 1'b1;
      cfg_data  = word;
      @(negedge pll_clk);
      cfg_write = 1'b0;
   endtask

   task automatic run_vector(input string tag, input eclock_pkg::cfg_word_t word,
                             input int pc, input int pl, input int pd, input int window);
      int slowest;
      slowest = pd;
      if (pc > slowest) slowest = pc;
      if (pl > slowest) slowest = pl;
      write_config(word);
      repeat (8 + 2 * slowest) @(negedge pll_clk);   // restart and gate settle
      measure_window(tag, pc, pl, pd, window);
   endtask

   // ##############################
   // watchdog
   // ##############################
   initial begin
      wait (budget_cycles > 0);
      #(budget_cycles * 100);
      $display("timeout after %0d cycles, tests did not complete", budget_cycles);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   // ##############################
   // main sequence
   // ##############################
   initial begin
      int                    i;
      int                    pc;
      int                    pl;
      int                    pd;
      int                    rc;
      int                    rl;
      int                    rd;
      int                    window;
      int                    sum_win;
      int                    cs;
      int                    ls;
      eclock_pkg::cfg_word_t word;

      rst       = 1'b1;
      cfg_write = 1'b0;
      cfg_data  = '0;
      $readmemh("test/eclock_vectors.txt", vec_mem);
      sum_win = 0;
      for (i = 0; i < NUM_VEC; i++) begin
         if ($isunknown(vec_mem[i*VEC_COLS+4]) || vec_mem[i*VEC_COLS+4] == 16'h0) begin
            $display("vector file missing or row %0d has no window length", i);
            $display("sim failed");
            $fatal(1, "bad vector file");
         end
         sum_win = sum_win + int'(vec_mem[i*VEC_COLS+4]);
      end
      budget_cycles = sum_win + RAND_RUNS * RAND_WINDOW
                      + (NUM_VEC + RAND_RUNS + 2) * SKIP_SLACK;

      // reset held over three rising edges
      repeat (3) begin
         @(negedge pll_clk);
         check_idle("reset");
      end
      rst = 1'b0;
      @(negedge pll_clk);
      check_idle("after reset");
      repeat (8 + 2 * 8) @(negedge pll_clk);
      measure_window("default", 2, 2, 8, 64);

      for (i = 0; i < NUM_VEC; i++) begin
         word   = vec_mem[i*VEC_COLS];
         pc     = int'(vec_mem[i*VEC_COLS+1]);
         pl     = int'(vec_mem[i*VEC_COLS+2]);
         pd     = int'(vec_mem[i*VEC_COLS+3]);
         window = int'(vec_mem[i*VEC_COLS+4]);
         expected_periods(word, rc, rl, rd);
         check_value($sformatf("vector file row %0d cclk period", i), rc, pc);
         check_value($sformatf("vector file row %0d lclk period", i), rl, pl);
         check_value($sformatf("vector file row %0d lclk_div4 period", i), rd, pd);
         run_vector($sformatf("vector %0d", i), word, pc, pl, pd, window);
      end

      // random settings 1..7 with both clocks enabled
      for (i = 0; i < RAND_RUNS; i++) begin
         cs   = 1 + int'($unsigned($random(seed)) % 7);
         ls   = 1 + int'($unsigned($random(seed)) % 7);
         word = {4'h0, 4'(ls), 4'(cs), 4'h3};
         expected_periods(word, rc, rl, rd);
         run_vector($sformatf("random %0d", i), word, rc, rl, rd, RAND_WINDOW);
      end

      $display("sim passed");
      $finish;
   end

endmodule

//--- hw/eclocks.sv
// elink clock generator top
`timescale 1ns/10ps

module eclocks (
   input  logic                  pll_clk,       // primary input clock
   input  logic                  rst,           // sync reset
   input  logic                  cfg_write,     // config write strobe
   input  eclock_pkg::cfg_word_t cfg_data,      // clock config word
   output logic                  cclk_p,        // Epiphany clock pair
   output logic                  cclk_n,
   output logic                  tx_lclk,       // tx serdes clock
   output logic                  tx_lclk90,     // center aligned tx clock
   output logic                  tx_lclk_div4   // tx parallel clock
);

   eclock_pkg::divcfg_t cclk_div;        // decoded settings
   eclock_pkg::divcfg_t lclk_div;
   eclock_pkg::divcfg_t lclk_div4_div;
   logic                cclk_en;
   logic                lclk_en;
   logic                restart;         // common phase realign
   logic                cclk;            // raw divider outputs
   logic                lclk;
   logic                lclk90;
   logic                lclk_div4;

   // ##############################
   // config decode
   // ##############################
   eclock_cfg cfg (
      .pll_clk       (pll_clk),
      .rst           (rst),
      .cfg_write     (cfg_write),
      .cfg_data      (cfg_data),
      .cclk_div      (cclk_div),
      .lclk_div      (lclk_div),
      .lclk_div4_div (lclk_div4_div),
      .cclk_en       (cclk_en),
      .lclk_en       (lclk_en),
      .restart       (restart)
   );

   // ##############################
   // dividers
   // ##############################
   clock_divider cclk_divider (
      .pll_clk  (pll_clk),
      .rst      (rst),
      .restart  (restart),
      .divcfg   (cclk_div),
      .clkout   (cclk),
      .clkout90 ()                       // no phase copy for cclk
   );

   clock_divider lclk_divider (
      .pll_clk  (pll_clk),
      .rst      (rst),
      .restart  (restart),
      .divcfg   (lclk_div),
      .clkout   (lclk),
      .clkout90 (lclk90)
   );

   // parallel clock, ignores the lclk enable
   clock_divider lclk_par_divider (
      .pll_clk  (pll_clk),
      .rst      (rst),
      .restart  (restart),
      .divcfg   (lclk_div4_div),
      .clkout   (lclk_div4),
      .clkout90 ()
   );

   // ##############################
   // output gating
   // ##############################
   eclock_gate gate (
      .pll_clk      (pll_clk),
      .rst          (rst),
      .cclk_en      (cclk_en),
      .lclk_en      (lclk_en),
      .cclk_in      (cclk),
      .lclk_in      (lclk),
      .lclk90_in    (lclk90),
      .lclk_div4_in (lclk_div4),
      .cclk_p       (cclk_p),
      .cclk_n       (cclk_n),
      .tx_lclk      (tx_lclk),
      .tx_lclk90    (tx_lclk90),
      .tx_lclk_div4 (tx_lclk_div4)
   );

endmodule

//--- hw/eclock_gate.sv
// glitch free clock output gating
`timescale 1ns/10ps

module eclock_gate (
   input  logic pll_clk,        // primary input clock
   input  logic rst,            // sync reset
   input  logic cclk_en,        // cclk enable level
   input  logic lclk_en,        // lclk enable level
   input  logic cclk_in,        // divided cclk
   input  logic lclk_in,        // divided lclk
   input  logic lclk90_in,      // lclk, quarter period later
   input  logic lclk_div4_in,   // parallel clock, never gated
   output logic cclk_p,         // cclk pair
   output logic cclk_n,
   output logic tx_lclk,        // serial clock
   output logic tx_lclk90,      // center aligned serial clock
   output logic tx_lclk_div4    // parallel clock
);

   eclock_pkg::gate_state_t cclk_state;
   eclock_pkg::gate_state_t lclk_state;
   logic                    cclk_low;    // safe point to switch cclk
   logic                    lclk_low;    // both lclk phases low
   logic                    cclk_pass;   // gated cclk level

   // shared switching rule, only move on/off while the source is low
   function automatic eclock_pkg::gate_state_t gate_next(
      input eclock_pkg::gate_state_t state,
      input logic                    en,
      input logic                    src_low
   );
      eclock_pkg::gate_state_t nxt;
      nxt = state;
      case (state)
         eclock_pkg::gate_off: begin
            if (en) nxt = eclock_pkg::gate_wait_low;
         end
         eclock_pkg::gate_wait_low: begin
            if (!en) begin
               nxt = eclock_pkg::gate_off;           // dropped before start
            end else if (src_low) begin
               nxt = eclock_pkg::gate_on;
            end
         end
         eclock_pkg::gate_on: begin
            if (!en && src_low) nxt = eclock_pkg::gate_off;  // finish pulse
         end
         default: nxt = eclock_pkg::gate_off;
      endcase
      return nxt;
   endfunction

   // ##############################
   // gate state
   // ##############################
   assign cclk_low = !cclk_in;
   assign lclk_low = !lclk_in && !lclk90_in;   // 90 copy trails lclk

   always_ff @(posedge pll_clk) begin
      if (rst) begin
         cclk_state <= eclock_pkg::gate_off;
         lclk_state <= eclock_pkg::gate_off;
      end else begin
         cclk_state <= gate_next(cclk_state, cclk_en, cclk_low);
         lclk_state <= gate_next(lclk_state, lclk_en, lclk_low);
      end
   end

   // ##############################
   // output stage
   // ##############################
   assign cclk_pass = (cclk_state == eclock_pkg::gate_on) && cclk_in;

   always_ff @(posedge pll_clk) begin
      if (rst) begin
         cclk_p       <= 1'b0;
         cclk_n       <= 1'b1;
         tx_lclk      <= 1'b0;
         tx_lclk90    <= 1'b0;
         tx_lclk_div4 <= 1'b0;
      end else begin
         cclk_p       <= cclk_pass;
         cclk_n       <= !cclk_pass;
         tx_lclk      <= (lclk_state == eclock_pkg::gate_on) && lclk_in;
         tx_lclk90    <= (lclk_state == eclock_pkg::gate_on) && lclk90_in;
         tx_lclk_div4 <= lclk_div4_in;                  // always running
      end
   end

   // pair stays complementary, including right after reset
   a_cclk_pair : assert property (
      @(posedge pll_clk) disable iff (rst)
      cclk_n == !cclk_p
   ) else $error("cclk_n not inverse of cclk_p");

endmodule

//--- hw/clock_divider.sv
// power of two clock divider
`timescale 1ns/10ps

module clock_divider (
   input  logic                pll_clk,   // primary input clock
   input  logic                rst,       // sync reset
   input  logic                restart,   // phase realign, clears counter
   input  eclock_pkg::divcfg_t divcfg,    // period is 2^divcfg, 0 = off
   output logic                clkout,    // divided clock, registered level
   output logic                clkout90   // same, quarter period later
);

   // period needs one bit more than the counter (128)
   typedef logic [eclock_pkg::CNT_W:0] span_t;

   eclock_pkg::divcfg_t n_eff;     // setting after clamp
   span_t               period;    // 2^n pll_clk cycles
   eclock_pkg::count_t  mask;      // counter wrap mask
   eclock_pkg::count_t  half;      // high time
   eclock_pkg::count_t  quarter;   // clkout90 lag
   eclock_pkg::count_t  cnt;       // phase counter
   eclock_pkg::count_t  cnt_pos;   // phase of clkout
   eclock_pkg::count_t  cnt_90;    // phase of clkout90
   logic                run;       // nonzero setting

   // assertion support
   eclock_pkg::count_t  high_run;  // cycles clkout has been high so far
   eclock_pkg::divcfg_t cfg_q;     // setting one cycle back

   // ##############################
   // setting decode
   // ##############################
   always_comb begin
      if (divcfg > eclock_pkg::divcfg_t'(eclock_pkg::DIV_MAX)) begin
         n_eff = eclock_pkg::divcfg_t'(eclock_pkg::DIV_MAX);
      end else begin
         n_eff = divcfg;
      end

      run    = (n_eff != '0);
      period = span_t'(1) << n_eff;           // 1 when off
      mask   = eclock_pkg::count_t'(period - span_t'(1));
      half   = eclock_pkg::count_t'(period >> 1);

      // setting 1 has no room for a quarter, 90 copy equals clkout
      if (n_eff > eclock_pkg::divcfg_t'(1)) begin
         quarter = eclock_pkg::count_t'(period >> 2);
      end else begin
         quarter = '0;
      end

      cnt_pos = cnt & mask;
      cnt_90  = (cnt - quarter) & mask;       // wraps negative to late phase
   end

   // ##############################
   // counter and outputs
   // ##############################
   always_ff @(posedge pll_clk) begin
      if (rst || restart) begin
         cnt      <= '0;
         clkout   <= 1'b0;                    // low for the first cycle
         clkout90 <= 1'b0;
      end else begin
         cnt      <= (cnt + eclock_pkg::count_t'(1)) & mask;
         clkout   <= run && (cnt_pos < half); // high for first half
         clkout90 <= run && (cnt_90 < half);
      end
   end

   // ##############################
   // high time tracking
   // ##############################
   always_ff @(posedge pll_clk) begin
      cfg_q <= divcfg;
      if (rst || restart || !clkout || (divcfg != cfg_q)) begin
         high_run <= '0;
      end else begin
         high_run <= high_run + eclock_pkg::count_t'(1);
      end
   end

   // with a settled setting the pulse never outlasts the half period
   a_half_period : assert property (
      @(posedge pll_clk) disable iff (rst)
      (clkout && run && (divcfg == cfg_q)) |-> (high_run < half)
   ) else $error("clkout high longer than half period");

   // the 90 copy only starts once clkout is already up
   a_lag_order : assert property (
      @(posedge pll_clk) disable iff (rst || restart)
      ($rose(clkout90) && run && (divcfg == cfg_q)) |-> clkout
   ) else $error("clkout90 rose while clkout low");

endmodule

//--- hw/eclock_cfg.sv
// clock config register and decode
`timescale 1ns/10ps

module eclock_cfg (
   input  logic                  pll_clk,        // primary input clock
   input  logic                  rst,            // sync reset
   input  logic                  cfg_write,      // one cycle write strobe
   input  eclock_pkg::cfg_word_t cfg_data,       // new config word
   output eclock_pkg::divcfg_t   cclk_div,       // clamped cclk setting
   output eclock_pkg::divcfg_t   lclk_div,       // clamped lclk setting
   output eclock_pkg::divcfg_t   lclk_div4_div,  // lclk setting + offset
   output logic                  cclk_en,        // cclk enable level
   output logic                  lclk_en,        // lclk enable level
   output logic                  restart         // realign all dividers
);

   // one extra bit so the offset add can't wrap
   typedef logic [eclock_pkg::DIV_W:0] div_sum_t;

   eclock_pkg::cfg_word_t cfg_reg;       // live config
   eclock_pkg::divcfg_t   cclk_raw;      // fields as written
   eclock_pkg::divcfg_t   lclk_raw;
   div_sum_t              div4_sum;      // lclk + offset before clamp

   // settings above DIV_MAX are treated as DIV_MAX
   function automatic eclock_pkg::divcfg_t clamp_div(input div_sum_t d);
      if (d > div_sum_t'(eclock_pkg::DIV_MAX)) begin
         return eclock_pkg::divcfg_t'(eclock_pkg::DIV_MAX);
      end
      return eclock_pkg::divcfg_t'(d);
   endfunction

   // ##############################
   // config register
   // ##############################
   always_ff @(posedge pll_clk) begin
      if (rst) begin
         cfg_reg <= eclock_pkg::CFG_RESET;
         restart <= 1'b0;
      end else begin
         if (cfg_write) begin
            cfg_reg <= cfg_data;
         end
         // pulse only on a real change and never twice in a row
         restart <= cfg_write && (cfg_data != cfg_reg) && !restart;
      end
   end

   // ##############################
   // field decode
   // ##############################
   always_comb begin
      cclk_raw = cfg_reg[eclock_pkg::CCLK_DIV_LSB +: eclock_pkg::DIV_W];
      lclk_raw = cfg_reg[eclock_pkg::LCLK_DIV_LSB +: eclock_pkg::DIV_W];

      cclk_div = clamp_div({1'b0, cclk_raw});
      lclk_div = clamp_div({1'b0, lclk_raw});

      // div4 clock is 2 settings slower than lclk and clamps at period 128
      div4_sum      = {1'b0, lclk_div} + div_sum_t'(eclock_pkg::DIV4_OFFSET);
      lclk_div4_div = clamp_div(div4_sum);

      cclk_en = cfg_reg[eclock_pkg::CCLK_EN_BIT];
      lclk_en = cfg_reg[eclock_pkg::LCLK_EN_BIT];
   end

   // ##############################
   // checks
   // ##############################
   // every divider sees one clean realign per change
   a_restart_single : assert property (
      @(posedge pll_clk) disable iff (rst)
      restart |=> !restart
   ) else $error("restart high two cycles in a row");

endmodule

//--- hw/eclock_pkg.sv
// elink clock generator definitions
package eclock_pkg;

   // ##############################
   // widths
   // ##############################
   localparam int CFG_W = 16;           // clock config word
   localparam int DIV_W = 4;            // one divide setting
   localparam int CNT_W = 7;            // divider counter, period up to 128

   // divide limits
   localparam int DIV_MAX     = 7;      // larger settings clamp here
   localparam int DIV4_OFFSET = 2;      // lclk_div4 runs 4x slower than lclk

   // ##############################
   // config word layout
   // ##############################
   localparam int CCLK_EN_BIT  = 0;     // cclk enable
   localparam int LCLK_EN_BIT  = 1;     // lclk enable
   localparam int CCLK_DIV_LSB = 4;     // cclk divide in [7:4]
   localparam int LCLK_DIV_LSB = 8;     // lclk divide in [11:8]

   // ##############################
   // types
   // ##############################
   typedef logic [CFG_W-1:0] cfg_word_t;   // full config word
   typedef logic [DIV_W-1:0] divcfg_t;     // divide setting, period 2^n
   typedef logic [CNT_W-1:0] count_t;      // divider phase counter

   // cclk and lclk at setting 1, both running
   localparam cfg_word_t CFG_RESET = 16'h0113;

   // per-clock output gating
   typedef enum logic [1:0] {
      gate_off,                         // output held low
      gate_wait_low,                    // enabled, waiting for source low
      gate_on                           // passing divided clock
   } gate_state_t;

endpackage
